// File: rtl/race_config.svh
`ifndef RACE_CONFIG_SVH
`define RACE_CONFIG_SVH

// Half-width of the tap window, window is 2L+1 taps
`define RACE_L 7

// Leak of the lag-correlation estimate
`define RACE_ALPHA_SHIFT 4

// Averaged correlation to edge weight
`define RACE_BETA_SHIFT 4

// Tap correlated against tap 0, legal range 1 to 2L
`define RACE_CORR_LAG 1

// AGC magnitude window on |I| + |Q|
`define RACE_AGC_LOW 4096
`define RACE_AGC_HIGH 24576
`define RACE_AGC_STEP 64

// Gain limits in Q3.12
`define RACE_GAIN_MIN 1024
`define RACE_GAIN_MAX 16383

`endif

// File: rtl/race_data_pkg.sv
package race_data_pkg;

  // Input and output samples, Q1.15
  typedef logic signed [15:0] sample_t;

  // Branch result before gain, Q2.15
  typedef logic signed [16:0] mac_t;

  // MAC accumulator, wide enough for 2L+1 full-scale products
  typedef logic signed [39:0] acc_t;

  // Tap weights and correlation estimates, Q1.15
  typedef logic signed [15:0] coeff_t;

  // AGC gain, unsigned Q3.12
  typedef logic [14:0] gain_t;

  // Index into the tap window
  typedef logic [3:0] tap_sel_t;

endpackage

// File: rtl/race_ctrl_pkg.sv
package race_ctrl_pkg;

  // Per-sample sequence
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ACCUM,
    SEQ_FINISH
  } seq_state_e;

  // Gain step decided from the input magnitude
  typedef enum logic [1:0] {
    GAIN_HOLD,
    GAIN_UP,
    GAIN_DOWN
  } agc_action_e;

endpackage

// File: rtl/race_sequencer.sv
`timescale 1ns/1ps
`include "race_config.svh"

module race_sequencer (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    strobe,
  output logic                    strobe_sync,
  output race_data_pkg::tap_sel_t sel,
  output logic                    accum_en,
  output logic                    coeff_load,
  output logic                    agc_en
);
  import race_data_pkg::*;
  import race_ctrl_pkg::*;

  localparam tap_sel_t SEL_LAST = tap_sel_t'(2 * `RACE_L);

  logic       meta_q;  // First stage, may go metastable
  logic       sync_q;
  logic       edge_q;  // Synced level one cycle back
  seq_state_e state;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
      edge_q <= 1'b0;
    end else begin
      meta_q <= strobe;
      sync_q <= meta_q;
      edge_q <= sync_q;
    end
  end

  assign strobe_sync = sync_q & ~edge_q;  // Rising edge only

  // A new strobe always wins and restarts the window
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state      <= SEQ_IDLE;
      sel        <= '0;
      accum_en   <= 1'b0;
      coeff_load <= 1'b0;
      agc_en     <= 1'b0;
    end else if (strobe_sync) begin
      state      <= SEQ_ACCUM;
      sel        <= '0;
      accum_en   <= 1'b1;
      coeff_load <= 1'b0;
      agc_en     <= 1'b0;
    end else begin
      case (state)
        SEQ_ACCUM: begin
          if (sel == SEL_LAST) begin  // Last tap goes in this cycle
            state      <= SEQ_FINISH;
            accum_en   <= 1'b0;
            coeff_load <= 1'b1;
            agc_en     <= 1'b1;
          end else begin
            sel <= sel + 1'b1;
          end
        end
        SEQ_FINISH: begin
          state      <= SEQ_IDLE;
          sel        <= '0;
          coeff_load <= 1'b0;
          agc_en     <= 1'b0;
        end
        default: begin
          accum_en   <= 1'b0;
          coeff_load <= 1'b0;
          agc_en     <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: rtl/race_branch.sv
`timescale 1ns/1ps
`include "race_config.svh"

module race_branch (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    strobe_sync,
  input  logic                    accum_en,
  input  logic                    coeff_load,
  input  race_data_pkg::tap_sel_t sel,
  input  race_data_pkg::sample_t  sample_in,
  input  race_data_pkg::coeff_t   w_edge,
  input  race_data_pkg::coeff_t   w_centre,
  output race_data_pkg::mac_t     mac_out,
  output race_data_pkg::coeff_t   rxx
);
  import race_data_pkg::*;

  localparam int       NTAPS      = 2 * `RACE_L + 1;
  localparam tap_sel_t SEL_CENTRE = tap_sel_t'(`RACE_L);

  sample_t            taps [NTAPS];  // taps[0] is the newest sample
  coeff_t             weight;
  logic signed [31:0] product;
  acc_t               acc;

  logic signed [31:0] lag_prod;
  logic signed [16:0] lag_scaled;    // Needs 17 bits for -1 * -1
  logic signed [17:0] rxx_delta;
  logic signed [17:0] rxx_next;

  // Centre tap gets its own weight
  assign weight  = (sel == SEL_CENTRE) ? w_centre : w_edge;
  assign product = taps[sel] * weight;

  // Leaky estimate of E[x(n) x(n-lag)]
  always_comb begin
    lag_prod   = taps[0] * taps[`RACE_CORR_LAG];
    lag_scaled = lag_prod[31:15];
    rxx_delta  = lag_scaled - rxx;
    rxx_next   = rxx + (rxx_delta >>> `RACE_ALPHA_SHIFT);
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      for (int i = 0; i < NTAPS; i++) begin
        taps[i] <= '0;
      end
      rxx <= '0;
    end else begin
      if (strobe_sync) begin
        taps[0] <= sample_in;
        for (int i = 1; i < NTAPS; i++) begin
          taps[i] <= taps[i-1];
        end
      end
      if (coeff_load) begin
        rxx <= rxx_next[15:0];  // Stays inside Q1.15 by construction
      end
    end
  end

  // Serial MAC, one tap per cycle
  always_ff @(posedge clk) begin
    if (strobe_sync) begin
      acc <= '0;
    end else if (accum_en) begin
      acc <= acc + product;
    end
  end

  always_ff @(posedge clk) begin
    if (coeff_load) begin
      mac_out <= mac_t'(acc >>> 15);  // Back to Q2.15
    end
  end

endmodule

// File: rtl/race_coeff.sv
`timescale 1ns/1ps
`include "race_config.svh"

module race_coeff (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  coeff_load,
  input  race_data_pkg::coeff_t rxx_real,
  input  race_data_pkg::coeff_t rxx_imag,
  output race_data_pkg::coeff_t w_edge,
  output race_data_pkg::coeff_t w_centre
);
  import race_data_pkg::*;

  logic signed [17:0] rxx_sum;
  coeff_t             avg;
  coeff_t             edge_raw;
  coeff_t             edge_next;
  logic signed [31:0] centre_next;

  always_comb begin
    rxx_sum   = rxx_real + rxx_imag + 18'sd1;  // Round half up
    avg       = rxx_sum[16:1];
    edge_raw  = avg >>> `RACE_BETA_SHIFT;
    edge_next = edge_raw[15] ? '0 : edge_raw;  // No negative edge taps

    // Keep the sum of all 2L+1 weights at unity
    centre_next = 32'sd32767 - (2 * `RACE_L) * edge_next;
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      w_edge   <= '0;
      w_centre <= 16'sd32767;  // Pass-through until first update
    end else if (coeff_load) begin
      w_edge   <= edge_next;
      w_centre <= coeff_t'(centre_next);
    end
  end

endmodule

// File: rtl/race_agc.sv
`timescale 1ns/1ps
`include "race_config.svh"

module race_agc (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   agc_en,
  input  race_data_pkg::mac_t    in_real,
  input  race_data_pkg::mac_t    in_imag,
  output race_data_pkg::sample_t out_real,
  output race_data_pkg::sample_t out_imag,
  output logic                   out_valid
);
  import race_data_pkg::*;
  import race_ctrl_pkg::*;

  localparam gain_t GAIN_UNITY = gain_t'(4096);  // 1.0 in Q3.12
  localparam gain_t GAIN_MIN   = gain_t'(`RACE_GAIN_MIN);
  localparam gain_t GAIN_MAX   = gain_t'(`RACE_GAIN_MAX);
  localparam gain_t GAIN_STEP  = gain_t'(`RACE_AGC_STEP);

  logic        apply_q;  // Branch results are registered on the agc_en edge
  gain_t       gain;
  logic [16:0] abs_real;
  logic [16:0] abs_imag;
  logic [17:0] mag;
  agc_action_e action;
  gain_t       gain_next;
  sample_t     sat_real;
  sample_t     sat_imag;

  // Rail times gain, back to Q1.15 with clamp
  function automatic sample_t scale_sat(mac_t rail, gain_t g);
    logic signed [32:0] prod;
    logic signed [32:0] scaled;
    prod   = rail * $signed({1'b0, g});
    scaled = prod >>> 12;
    if (scaled > 33'sd32767) begin
      return 16'sh7fff;
    end else if (scaled < -33'sd32768) begin
      return 16'sh8000;
    end
    return scaled[15:0];
  endfunction

  assign sat_real = scale_sat(in_real, gain);  // Old gain, before the step
  assign sat_imag = scale_sat(in_imag, gain);

  // L1 magnitude is enough for a level window
  assign abs_real = in_real[16] ? -in_real : in_real;
  assign abs_imag = in_imag[16] ? -in_imag : in_imag;
  assign mag      = abs_real + abs_imag;

  always_comb begin
    if (mag > `RACE_AGC_HIGH) begin
      action = GAIN_DOWN;
    end else if (mag < `RACE_AGC_LOW) begin
      action = GAIN_UP;
    end else begin
      action = GAIN_HOLD;
    end

    gain_next = gain;
    case (action)
      GAIN_UP:   gain_next = (gain > GAIN_MAX - GAIN_STEP) ? GAIN_MAX : gain + GAIN_STEP;
      GAIN_DOWN: gain_next = (gain < GAIN_MIN + GAIN_STEP) ? GAIN_MIN : gain - GAIN_STEP;
      default:   gain_next = gain;
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      apply_q   <= 1'b0;
      out_valid <= 1'b0;
      out_real  <= '0;
      out_imag  <= '0;
      gain      <= GAIN_UNITY;
    end else begin
      apply_q   <= agc_en;
      out_valid <= apply_q;  // Outputs hold between pulses
      if (apply_q) begin
        out_real <= sat_real;
        out_imag <= sat_imag;
        gain     <= gain_next;
      end
    end
  end

endmodule

// File: rtl/race_top.sv
`timescale 1ns/1ps

module race_top (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   strobe,
  input  race_data_pkg::sample_t in_real,
  input  race_data_pkg::sample_t in_imag,
  output race_data_pkg::sample_t out_real,
  output race_data_pkg::sample_t out_imag,
  output logic                   out_valid
);
  import race_data_pkg::*;

  logic     strobe_sync;
  logic     accum_en;
  logic     coeff_load;
  logic     agc_en;
  tap_sel_t sel;
  mac_t     mac_out_real;
  mac_t     mac_out_imag;
  coeff_t   rxx_real;
  coeff_t   rxx_imag;
  coeff_t   w_edge;    // Shared by both rails
  coeff_t   w_centre;

  race_sequencer i_sequencer (
    .clk         (clk),
    .nrst        (nrst),
    .strobe      (strobe),
    .strobe_sync (strobe_sync),
    .sel         (sel),
    .accum_en    (accum_en),
    .coeff_load  (coeff_load),
    .agc_en      (agc_en)
  );

  race_branch i_branch_real (
    .clk         (clk),
    .nrst        (nrst),
    .strobe_sync (strobe_sync),
    .accum_en    (accum_en),
    .coeff_load  (coeff_load),
    .sel         (sel),
    .sample_in   (in_real),
    .w_edge      (w_edge),
    .w_centre    (w_centre),
    .mac_out     (mac_out_real),
    .rxx         (rxx_real)
  );

  race_branch i_branch_imag (
    .clk         (clk),
    .nrst        (nrst),
    .strobe_sync (strobe_sync),
    .accum_en    (accum_en),
    .coeff_load  (coeff_load),
    .sel         (sel),
    .sample_in   (in_imag),
    .w_edge      (w_edge),
    .w_centre    (w_centre),
    .mac_out     (mac_out_imag),
    .rxx         (rxx_imag)
  );

  race_coeff i_coeff (
    .clk        (clk),
    .nrst       (nrst),
    .coeff_load (coeff_load),
    .rxx_real   (rxx_real),
    .rxx_imag   (rxx_imag),
    .w_edge     (w_edge),
    .w_centre   (w_centre)
  );

  race_agc i_agc (
    .clk       (clk),
    .nrst      (nrst),
    .agc_en    (agc_en),
    .in_real   (mac_out_real),
    .in_imag   (mac_out_imag),
    .out_real  (out_real),
    .out_imag  (out_imag),
    .out_valid (out_valid)
  );

endmodule

// File: verif/race_tb.sv
`timescale 1ns/1ps
`include "race_config.svh"

module race_tb;
  import race_data_pkg::*;

  localparam int          NTAPS     = 2 * `RACE_L + 1;
  localparam int          LATENCY   = 2 * `RACE_L + 6;  // Strobe edge to out_valid
  localparam int          MAX_RUN   = 400;
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

  logic    clk;
  logic    nrst;
  logic    strobe;
  sample_t in_real;
  sample_t in_imag;
  sample_t out_real;
  sample_t out_imag;
  logic    out_valid;

  logic [31:0] lfsr;
  longint      m_taps_r [NTAPS];  // Reference model state
  longint      m_taps_i [NTAPS];
  longint      m_rxx_r;
  longint      m_rxx_i;
  longint      m_w_edge;
  longint      m_w_centre;
  longint      m_gain;
  longint      exp_r;             // Expected outputs of the last sample sent
  longint      exp_i;

  race_top dut (.*);

  always #2 clk = ~clk;

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_value(input string name, input longint got, input longint expected);
    assert (got == expected) else begin
      $display("[ERROR] time %0t: %s got %0d expected %0d", $time, name, got, expected);
      stop_run();
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    assert (ok) else begin
      $display("Check failed at time %0t: %s", $time, what);
      stop_run();
    end
  endtask

  // Galois LFSR, one step per bit, result sign-extended from n bits
  function automatic sample_t rand_sample(int n);
    logic [15:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val  = {val[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
    end
    if (n < 16 && val[n-1]) begin
      val = val | (16'hffff << n);
    end
    return val;
  endfunction

  function automatic longint saturate16(longint v);
    if (v > 32767) begin
      return 32767;
    end else if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  task automatic reset_model();
    for (int k = 0; k < NTAPS; k++) begin
      m_taps_r[k] = 0;
      m_taps_i[k] = 0;
    end
    m_rxx_r    = 0;
    m_rxx_i    = 0;
    m_w_edge   = 0;
    m_w_centre = 32767;
    m_gain     = 4096;  // 1.0 in Q3.12
  endtask

  task automatic predict_sample(input longint xr, input longint xi);
    longint mac_r;
    longint mac_i;
    longint w;
    longint edge_w;
    longint mag;
    mac_r = 0;
    mac_i = 0;
    for (int k = NTAPS - 1; k > 0; k--) begin
      m_taps_r[k] = m_taps_r[k-1];
      m_taps_i[k] = m_taps_i[k-1];
    end
    m_taps_r[0] = xr;
    m_taps_i[0] = xi;
    for (int k = 0; k < NTAPS; k++) begin
      w     = (k == `RACE_L) ? m_w_centre : m_w_edge;
      mac_r = mac_r + m_taps_r[k] * w;
      mac_i = mac_i + m_taps_i[k] * w;
    end
    mac_r = mac_r >>> 15;
    mac_i = mac_i >>> 15;
    // New weights from the correlation held before this update
    edge_w = ((m_rxx_r + m_rxx_i + 1) >>> 1) >>> `RACE_BETA_SHIFT;
    if (edge_w < 0) begin
      edge_w = 0;
    end
    m_rxx_r = m_rxx_r + ((((m_taps_r[0] * m_taps_r[`RACE_CORR_LAG]) >>> 15) - m_rxx_r)
              >>> `RACE_ALPHA_SHIFT);
    m_rxx_i = m_rxx_i + ((((m_taps_i[0] * m_taps_i[`RACE_CORR_LAG]) >>> 15) - m_rxx_i)
              >>> `RACE_ALPHA_SHIFT);
    m_w_edge   = edge_w;
    m_w_centre = 32767 - 2 * `RACE_L * edge_w;
    exp_r = saturate16((mac_r * m_gain) >>> 12);  // Gain before the step
    exp_i = saturate16((mac_i * m_gain) >>> 12);
    mag   = (mac_r < 0 ? -mac_r : mac_r) + (mac_i < 0 ? -mac_i : mac_i);
    if (mag > `RACE_AGC_HIGH) begin
      m_gain = (m_gain - `RACE_AGC_STEP < `RACE_GAIN_MIN) ? `RACE_GAIN_MIN
               : m_gain - `RACE_AGC_STEP;
    end else if (mag < `RACE_AGC_LOW) begin
      m_gain = (m_gain + `RACE_AGC_STEP > `RACE_GAIN_MAX) ? `RACE_GAIN_MAX
               : m_gain + `RACE_AGC_STEP;
    end
  endtask

  task automatic apply_reset();
    nrst = 1'b0;
    reset_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
  endtask

  // One strobe, sample held until the result is checked
  task automatic send_sample(input sample_t xr, input sample_t xi);
    int cycles;
    predict_sample(xr, xi);
    @(negedge clk);
    in_real = xr;
    in_imag = xi;
    strobe  = 1'b1;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles == 2) begin
        strobe = 1'b0;
      end
    end while (!out_valid && cycles < 4 * LATENCY);
    check_cond(out_valid, "timeout while waiting for out_valid");
    check_value("latency", cycles, LATENCY);
    check_value("out_real", out_real, exp_r);
    check_value("out_imag", out_imag, exp_i);
    @(negedge clk);
    check_cond(!out_valid, "out_valid stayed high for more than one cycle");
    repeat (2) @(negedge clk);  // Keeps strobes 2L+8 cycles apart
  endtask

  task automatic idle_and_latency();
    for (int c = 0; c < 3 * LATENCY; c++) begin
      @(negedge clk);
      check_cond(!out_valid, "out_valid pulsed without a strobe");
      check_value("out_real", out_real, 0);
      check_value("out_imag", out_imag, 0);
    end
    send_sample(rand_sample(16), rand_sample(16));
  endtask

  task automatic impulse_response();
    longint xr;
    longint xi;
    longint g;
    xr = 20000;
    xi = -12345;
    apply_reset();
    send_sample(xr, xi);
    for (int n = 1; n <= 2 * `RACE_L; n++) begin
      send_sample(0, 0);
      if (n == `RACE_L) begin
        // Impulse on the centre tap, gain raised by L quiet outputs
        g = 4096 + `RACE_L * `RACE_AGC_STEP;
        check_value("out_real", out_real, (((xr * 32767) >>> 15) * g) >>> 12);
        check_value("out_imag", out_imag, (((xi * 32767) >>> 15) * g) >>> 12);
      end
    end
  endtask

  task automatic random_stream();
    for (int n = 0; n < 60; n++) begin
      send_sample(rand_sample(16), rand_sample(16));
    end
  endtask

  task automatic gain_up_saturation();
    int n;
    n = 0;
    while ((m_gain != `RACE_GAIN_MAX || n < NTAPS) && n < MAX_RUN) begin
      send_sample(rand_sample(8), rand_sample(8));
      n++;
    end
    check_cond(m_gain == `RACE_GAIN_MAX, "gain did not rise to its maximum");
    for (int k = 0; k <= `RACE_L; k++) begin
      send_sample(16'sh7fff, 16'sh8000);
    end
    check_value("out_real", out_real, 32767);   // Full scale on the centre tap
    check_value("out_imag", out_imag, -32768);
  endtask

  task automatic gain_down_run();
    longint full;
    longint start_mag;
    int     n;
    full      = 30000;
    start_mag = 0;
    n         = 0;
    while ((m_gain != `RACE_GAIN_MIN || n < NTAPS) && n < MAX_RUN) begin
      send_sample(full, -full);
      n++;
      if (n == NTAPS) begin
        start_mag = out_real;
      end
    end
    check_cond(m_gain == `RACE_GAIN_MIN, "gain did not fall to its minimum");
    // Weights always sum to 32767, so the window passes the level through
    send_sample(full, -full);
    check_value("out_real", out_real, (((full * 32767) >>> 15) * `RACE_GAIN_MIN) >>> 12);
    check_value("out_imag", out_imag, (((-full * 32767) >>> 15) * `RACE_GAIN_MIN) >>> 12);
    check_cond(out_real < start_mag, "output did not shrink as the gain fell");
  endtask

  initial begin
    clk     = 1'b0;
    nrst    = 1'b0;
    strobe  = 1'b0;
    in_real = '0;
    in_imag = '0;
    lfsr    = 32'h757b_0ddb;
    apply_reset();
    idle_and_latency();
    impulse_response();
    random_stream();
    gain_up_saturation();
    gain_down_run();  // Starts near maximum gain
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/race_data_pkg.sv
rtl/race_ctrl_pkg.sv
rtl/race_sequencer.sv
rtl/race_branch.sv
rtl/race_coeff.sv
rtl/race_agc.sv
rtl/race_top.sv
verif/race_tb.sv

// File: Bender.yml
package:
  name: race

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/race_data_pkg.sv
      - rtl/race_ctrl_pkg.sv
      - rtl/race_sequencer.sv
      - rtl/race_branch.sv
      - rtl/race_coeff.sv
      - rtl/race_agc.sv
      - rtl/race_top.sv
  - target: simulation
    files:
      - verif/race_tb.sv
